//--- hw/hist_params.svh
`ifndef HIST_PARAMS_SVH
`define HIST_PARAMS_SVH

// time bins in one pixel histogram
`define HIST_BINS 16

// pixels held in one bank
`define HIST_PIXELS 4

// hits taken per pixel before moving on
`define HIST_SAMPLES 3

// passes over all pixels per histogram set, at least 2
`define HIST_ACQS 2

// count width, saturates at all ones
`define HIST_COUNT_W 4

// words per bank, pixel in upper address bits
`define HIST_DEPTH (`HIST_PIXELS * `HIST_BINS)

`endif

//--- hw/hist_data_pkg.sv
`default_nettype none

`include "hist_params.svh"

package hist_data_pkg;

    // time-bin index carried by a hit
    typedef logic [$clog2(`HIST_BINS)-1:0] hist_bin_t;

    // pixel index from the sequencer
    typedef logic [$clog2(`HIST_PIXELS)-1:0] hist_pixel_t;

    // bank word address, {pixel, bin}
    typedef logic [$clog2(`HIST_DEPTH)-1:0] hist_addr_t;

    // one bin count
    typedef logic [`HIST_COUNT_W-1:0] hist_count_t;

endpackage

`default_nettype wire

//--- hw/hist_ctrl_pkg.sv
`default_nettype none

`include "hist_params.svh"

package hist_ctrl_pkg;

    // sample counter inside one pixel
    typedef logic [$clog2(`HIST_SAMPLES)-1:0] hist_sample_cnt_t;

    // acquisition counter inside one set
    typedef logic [$clog2(`HIST_ACQS)-1:0] hist_acq_cnt_t;

    // readout engine states
    typedef enum logic [1:0] {
        st_init,
        st_idle,
        st_stream
    } hist_rd_state_t;

endpackage

`default_nettype wire

//--- hw/hist_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface hist_mem_if;
    import hist_data_pkg::*;

    // read port, data one cycle after rd_en
    logic        rd_en;
    hist_addr_t  rd_addr;
    hist_count_t rd_data;

    // write port, lands on the edge with wr_en high
    logic        wr_en;
    hist_addr_t  wr_addr;
    hist_count_t wr_data;

    modport requester (
        output rd_en, rd_addr, wr_en, wr_addr, wr_data,
        input  rd_data
    );

    modport bank (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

//--- hw/hist_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_params.svh"

module hist_sequencer (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      advance,
    output hist_data_pkg::hist_pixel_t pixel,
    output logic                      set_done
);
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    hist_sample_cnt_t sample_q;
    hist_pixel_t      pixel_q;
    hist_acq_cnt_t    acq_q;
    logic             last_sample;
    logic             last_pixel;
    logic             last_acq;

    // wrap points of the three nested counters
    assign last_sample = (sample_q == hist_sample_cnt_t'(`HIST_SAMPLES - 1));
    assign last_pixel  = (pixel_q == hist_pixel_t'(`HIST_PIXELS - 1));
    assign last_acq    = (acq_q == hist_acq_cnt_t'(`HIST_ACQS - 1));

    // the hit in this cycle belongs to this pixel
    assign pixel = pixel_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sample_q <= '0;
            pixel_q  <= '0;
            acq_q    <= '0;
            set_done <= 1'b0;
        end else begin
            // single-cycle strobe
            set_done <= 1'b0;
            if (advance) begin
                if (!last_sample) begin
                    sample_q <= sample_q + 1'b1;
                end else begin
                    sample_q <= '0;
                    if (!last_pixel) begin
                        pixel_q <= pixel_q + 1'b1;
                    end else begin
                        pixel_q <= '0;
                        if (!last_acq) begin
                            acq_q <= acq_q + 1'b1;
                        end else begin
                            // final hit of the set, all counters wrap
                            acq_q    <= '0;
                            set_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/hist_builder.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     hit,
    input  hist_data_pkg::hist_bin_t hit_bin,
    input  logic                     ready,
    output logic                     set_done,
    hist_mem_if.requester            mem
);
    import hist_data_pkg::*;

    logic        advance;
    hist_pixel_t pixel;

    // stage 1, read issued
    logic        s1_valid;
    hist_addr_t  s1_addr;

    // stage 2, write issued
    logic        s2_valid;
    logic        s2_last;
    hist_addr_t  s2_addr;

    // last write, for back-to-back hits
    logic        fwd_valid;
    hist_addr_t  fwd_addr;
    hist_count_t fwd_count;

    hist_count_t base_count;
    hist_count_t next_count;

    // hits before the clear sweep ends are dropped
    assign advance = hit && ready;

    hist_sequencer i_sequencer (
        .clk      (clk),
        .res      (res),
        .advance  (advance),
        .pixel    (pixel),
        .set_done (set_done)
    );

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s2_last   <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            s1_valid <= advance;
            s2_valid <= s1_valid;
            // set_done lines up with the completing hit in stage 1
            s2_last  <= s1_valid && set_done;
            // no forwarding across a bank swap
            fwd_valid <= s2_valid && !s2_last;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr   <= {pixel, hit_bin};
        s2_addr   <= s1_addr;
        fwd_addr  <= s2_addr;
        fwd_count <= next_count;
    end

    // read returns stale data when the previous write hit the same word
    assign base_count = (fwd_valid && (fwd_addr == s2_addr)) ? fwd_count : mem.rd_data;
    // hold at all ones
    assign next_count = (base_count == '1) ? base_count : base_count + 1'b1;

    assign mem.rd_en   = s1_valid;
    assign mem.rd_addr = s1_addr;
    assign mem.wr_en   = s2_valid;
    assign mem.wr_addr = s2_addr;
    assign mem.wr_data = next_count;

    // every write is the second half of a read one cycle earlier
    a_wr_after_rd : assert property (@(posedge clk) disable iff (!res)
        mem.wr_en |-> ($past(mem.rd_en) && ($past(mem.rd_addr) == mem.wr_addr)));

endmodule

`default_nettype wire

//--- hw/hist_bank_pair.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_params.svh"

module hist_bank_pair (
    input  logic     clk,
    input  logic     res,
    input  logic     set_done,
    hist_mem_if.bank build_mem,
    hist_mem_if.bank read_mem
);
    import hist_data_pkg::*;

    // bank the builder reads, readout owns the other
    logic        sel_q;
    // bank of the builder read in flight, tags its write
    logic        build_bank_q;
    // readout bank, frozen while a stream runs
    logic        read_bank;
    logic        read_bank_q;
    // clear sweep after reset writes both banks
    logic        init_q;
    hist_count_t bank_rd [2];

    assign read_bank = read_mem.rd_en ? read_bank_q : ~sel_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sel_q        <= 1'b0;
            build_bank_q <= 1'b0;
            read_bank_q  <= 1'b1;
            init_q       <= 1'b1;
        end else begin
            sel_q       <= sel_q ^ set_done;
            read_bank_q <= read_bank;
            if (build_mem.rd_en) begin
                build_bank_q <= sel_q;
            end
            if (read_mem.wr_en && (read_mem.wr_addr == hist_addr_t'(`HIST_DEPTH - 1))) begin
                init_q <= 1'b0;
            end
        end
    end

    for (genvar k = 0; k < 2; k++) begin : g_bank
        localparam logic bank_id = 1'(k);

        hist_count_t words [`HIST_DEPTH];
        hist_count_t rd_q;
        logic        b_rd;
        logic        r_rd;
        logic        b_wr;
        logic        r_wr;

        assign b_rd = build_mem.rd_en && (sel_q == bank_id);
        assign r_rd = read_mem.rd_en && (read_bank == bank_id);
        // builder write follows its tag, not the current select
        assign b_wr = build_mem.wr_en && (build_bank_q == bank_id);
        assign r_wr = read_mem.wr_en && (init_q || (read_bank == bank_id));

        // read-first, a read and a write on one edge return the old word
        always_ff @(posedge clk) begin
            if (b_rd) begin
                rd_q <= words[build_mem.rd_addr];
            end else if (r_rd) begin
                rd_q <= words[read_mem.rd_addr];
            end
            if (b_wr) begin
                words[build_mem.wr_addr] <= build_mem.wr_data;
            end else if (r_wr) begin
                words[read_mem.wr_addr] <= read_mem.wr_data;
            end
        end

        assign bank_rd[k] = rd_q;
    end

    assign build_mem.rd_data = bank_rd[build_bank_q];
    assign read_mem.rd_data  = bank_rd[read_bank_q];

    // builder and readout never share a bank on a write
    a_bank_excl : assert property (@(posedge clk) disable iff (!res)
        !(build_mem.wr_en && read_mem.wr_en && (init_q || (build_bank_q == read_bank))));

endmodule

`default_nettype wire

//--- hw/hist_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_params.svh"

module hist_readout (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       set_done,
    hist_mem_if.requester              mem,
    output logic                       ready,
    output logic                       rd_valid,
    output hist_data_pkg::hist_pixel_t rd_pixel,
    output hist_data_pkg::hist_bin_t   rd_bin,
    output hist_data_pkg::hist_count_t rd_count,
    output logic                       overrun
);
    import hist_data_pkg::*;
    import hist_ctrl_pkg::*;

    hist_rd_state_t           state_q;
    // one bit wider than an address, reaches HIST_DEPTH
    logic [$bits(hist_addr_t):0] cnt_q;
    // set_done seen while idle, start next cycle
    logic                     go_q;
    logic                     valid_q;
    logic                     overrun_q;
    hist_addr_t               addr_q;
    logic                     reading;

    assign reading = (state_q == st_stream) && (cnt_q < `HIST_DEPTH);

    // read and clear the same word, zero also during the sweep
    assign mem.rd_en   = reading;
    assign mem.rd_addr = cnt_q[$bits(hist_addr_t)-1:0];
    assign mem.wr_en   = reading || (state_q == st_init);
    assign mem.wr_addr = cnt_q[$bits(hist_addr_t)-1:0];
    assign mem.wr_data = '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state_q   <= st_init;
            cnt_q     <= '0;
            go_q      <= 1'b0;
            valid_q   <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            valid_q <= reading;
            go_q    <= set_done && (state_q == st_idle) && !go_q;
            // sticky, the running stream is left alone
            if (set_done && ((state_q == st_stream) || go_q)) begin
                overrun_q <= 1'b1;
            end
            case (state_q)
                st_init: begin
                    if (cnt_q == `HIST_DEPTH - 1) begin
                        state_q <= st_idle;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                st_idle: begin
                    if (go_q) begin
                        state_q <= st_stream;
                    end
                end
                st_stream: begin
                    // stay one extra cycle for the last word
                    if (cnt_q == `HIST_DEPTH) begin
                        state_q <= st_idle;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_init;
                    cnt_q   <= '0;
                end
            endcase
        end
    end

    // address of the word now on rd_data
    always_ff @(posedge clk) begin
        addr_q <= mem.rd_addr;
    end

    assign ready    = (state_q != st_init);
    assign rd_valid = valid_q;
    assign rd_pixel = addr_q[$bits(hist_addr_t)-1:$bits(hist_bin_t)];
    assign rd_bin   = addr_q[$bits(hist_bin_t)-1:0];
    assign rd_count = mem.rd_data;
    assign overrun  = overrun_q;

    // the output word lags its read by one cycle, still inside the stream
    a_valid_in_stream : assert property (@(posedge clk) disable iff (!res)
        rd_valid |-> (state_q == st_stream));

endmodule

`default_nettype wire

//--- hw/hist_top.sv
`timescale 1ns/1ps
`default_nettype none

module hist_top (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       hit,
    input  hist_data_pkg::hist_bin_t   hit_bin,
    output logic                       ready,
    output logic                       set_done,
    output logic                       rd_valid,
    output hist_data_pkg::hist_pixel_t rd_pixel,
    output hist_data_pkg::hist_bin_t   rd_bin,
    output hist_data_pkg::hist_count_t rd_count,
    output logic                       overrun
);

    // builder side and readout side of the ping-pong memory
    hist_mem_if build_mem ();
    hist_mem_if read_mem ();

    // increments bins in the active bank
    hist_builder i_builder (
        .clk      (clk),
        .res      (res),
        .hit      (hit),
        .hit_bin  (hit_bin),
        .ready    (ready),
        .set_done (set_done),
        .mem      (build_mem.requester)
    );

    // swaps banks on set_done
    hist_bank_pair i_bank_pair (
        .clk       (clk),
        .res       (res),
        .set_done  (set_done),
        .build_mem (build_mem.bank),
        .read_mem  (read_mem.bank)
    );

    // clear sweep, then read-and-clear of the finished bank
    hist_readout i_readout (
        .clk      (clk),
        .res      (res),
        .set_done (set_done),
        .mem      (read_mem.requester),
        .ready    (ready),
        .rd_valid (rd_valid),
        .rd_pixel (rd_pixel),
        .rd_bin   (rd_bin),
        .rd_count (rd_count),
        .overrun  (overrun)
    );

endmodule

`default_nettype wire

//--- testbench/tb_hist_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_params.svh"

module tb_hist_top;
    import hist_data_pkg::*;

    localparam int PERIOD   = 8;
    localparam int SET_HITS = `HIST_SAMPLES * `HIST_PIXELS * `HIST_ACQS;
    localparam int NSETS    = 13;
    localparam int NSTREAMS = 9;
    localparam int MAX_CNT  = (1 << `HIST_COUNT_W) - 1;
    // random gaps stretch a set to at most four cycles per hit
    localparam int LIMIT    = (NSETS + 1) * (SET_HITS * 4 + `HIST_DEPTH + 32) * PERIOD;

    logic        clk;
    logic        res;
    logic        hit;
    hist_bin_t   hit_bin;
    logic        ready;
    logic        set_done;
    logic        rd_valid;
    hist_pixel_t rd_pixel;
    hist_bin_t   rd_bin;
    hist_count_t rd_count;
    logic        overrun;

    // expected counts, one array per bank
    int model [2][`HIST_DEPTH];
    // hits the DUT has accepted so far, drives the pixel rule
    int hit_n;
    // bin used by every one-bin set, so dropped sets pile up in one word
    int sat_bin;

    // compare process state
    int busy;
    int lead;
    int word;
    int rd_idx;
    int fill_sel;
    int exp_ovr;
    int sd_next;
    int acc_n;
    int words_seen;

    hist_top i_hist_top (
        .clk      (clk),
        .res      (res),
        .hit      (hit),
        .hit_bin  (hit_bin),
        .ready    (ready),
        .set_done (set_done),
        .rd_valid (rd_valid),
        .rd_pixel (rd_pixel),
        .rd_bin   (rd_bin),
        .rd_count (rd_count),
        .overrun  (overrun)
    );

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        string line;
        if (got !== exp) begin
            line = $sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_stop(line);
        end
    endtask

    // reference model, one accepted hit
    function automatic void model_hit(input int bin);
        int set_no;
        int pix;
        int addr;
        set_no = hit_n / SET_HITS;
        // samples per pixel, then next pixel, wrapping each acquisition
        pix  = (hit_n / `HIST_SAMPLES) % `HIST_PIXELS;
        addr = pix * `HIST_BINS + bin;
        // sets alternate between the two banks
        if (model[set_no % 2][addr] < MAX_CNT) begin
            model[set_no % 2][addr] = model[set_no % 2][addr] + 1;
        end
        hit_n = hit_n + 1;
    endfunction

    // mode 0 random bins with gaps, 1 one bin back to back, 2 random back to back
    task automatic send_set(input int mode);
        int i;
        int bin;
        int gap;
        for (i = 0; i < SET_HITS; i++) begin
            bin = (mode == 1) ? sat_bin : $urandom_range(`HIST_BINS - 1);
            @(negedge clk);
            check_value("ready", ready, 1);
            hit     = 1'b1;
            hit_bin = hist_bin_t'(bin);
            model_hit(bin);
            gap = (mode == 0) ? $urandom_range(3) : 0;
            repeat (gap) begin
                @(negedge clk);
                hit     = 1'b0;
                // idle bins are noise and must not count
                hit_bin = hist_bin_t'($urandom_range(`HIST_BINS - 1));
            end
        end
        @(negedge clk);
        hit = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #(LIMIT);
        fail_stop("timeout, the DUT stopped producing results");
    end

    // sampled at posedge, DUT values from before the edge
    initial begin : compare
        int exp_valid;
        busy       = 0;
        lead       = 0;
        word       = 0;
        rd_idx     = 0;
        fill_sel   = 0;
        exp_ovr    = 0;
        sd_next    = 0;
        acc_n      = 0;
        words_seen = 0;
        forever begin
            @(posedge clk);
            // set_done one cycle after the completing hit
            check_value("set_done", set_done, sd_next);
            sd_next = (hit && ready && ((acc_n + 1) % SET_HITS == 0)) ? 1 : 0;
            if (hit && ready) begin
                acc_n = acc_n + 1;
            end
            check_value("overrun", overrun, exp_ovr);
            // first word three cycles after set_done
            if (busy && lead > 0) begin
                lead = lead - 1;
            end
            exp_valid = (busy && lead == 0) ? 1 : 0;
            check_value("rd_valid", rd_valid, exp_valid);
            if (set_done) begin
                if (busy) begin
                    // dropped set, the stream runs on
                    exp_ovr = 1;
                end else begin
                    busy   = 1;
                    lead   = 3;
                    word   = 0;
                    rd_idx = fill_sel;
                end
                fill_sel = 1 - fill_sel;
            end
            if (exp_valid) begin
                check_value("rd_pixel", rd_pixel, word / `HIST_BINS);
                check_value("rd_bin", rd_bin, word % `HIST_BINS);
                check_value("rd_count", rd_count, model[rd_idx][word]);
                // word is cleared as it streams
                model[rd_idx][word] = 0;
                word       = word + 1;
                words_seen = words_seen + 1;
                if (word == `HIST_DEPTH) begin
                    busy = 0;
                end
            end
        end
    end

    initial begin : stimulus
        int k;
        void'($urandom(16));
        for (k = 0; k < `HIST_DEPTH; k++) begin
            model[0][k] = 0;
            model[1][k] = 0;
        end
        hit_n   = 0;
        sat_bin = $urandom_range(`HIST_BINS - 1);
        hit     = 1'b0;
        hit_bin = '0;
        res     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        check_value("ready", ready, 0);
        check_value("set_done", set_done, 0);
        check_value("rd_valid", rd_valid, 0);
        check_value("overrun", overrun, 0);

        // hits during the clear sweep are dropped
        while (!ready) begin
            hit     = 1'b1;
            hit_bin = hist_bin_t'($urandom_range(`HIST_BINS - 1));
            @(negedge clk);
        end
        hit = 1'b0;

        // random set with gaps
        send_set(0);
        wait (words_seen == `HIST_DEPTH);
        // one bin, every cycle
        send_set(1);
        wait (words_seen == 2 * `HIST_DEPTH);
        // back in the first bank, must start from zero
        send_set(0);
        wait (words_seen == 3 * `HIST_DEPTH);
        // next set completes while this one streams
        send_set(0);
        send_set(2);
        wait (words_seen == 4 * `HIST_DEPTH);
        // window for a stray stream of the dropped set
        repeat (16) @(negedge clk);
        check_value("overrun", overrun, 1);

        // dropped one-bin sets stack up in bank 0 past the count maximum
        for (k = 0; k < 3; k++) begin
            send_set(0);
            send_set(1);
            wait (words_seen == (5 + k) * `HIST_DEPTH);
        end
        // bank 1 streamed, then bank 0 with its saturated words
        send_set(0);
        wait (words_seen == 8 * `HIST_DEPTH);
        send_set(0);
        wait (words_seen == NSTREAMS * `HIST_DEPTH);

        if (words_seen == NSTREAMS * `HIST_DEPTH && exp_ovr == 1) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_stop("wrong number of streamed words or overrun never seen");
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/hist_data_pkg.sv
hw/hist_ctrl_pkg.sv
hw/hist_mem_if.sv
hw/hist_sequencer.sv
hw/hist_builder.sv
hw/hist_bank_pair.sv
hw/hist_readout.sv
hw/hist_top.sv
testbench/tb_hist_top.sv

//--- Bender.yml
package:
  name: hist_builder

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/hist_data_pkg.sv
      - hw/hist_ctrl_pkg.sv
      - hw/hist_mem_if.sv
      - hw/hist_sequencer.sv
      - hw/hist_builder.sv
      - hw/hist_bank_pair.sv
      - hw/hist_readout.sv
      - hw/hist_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_hist_top.sv
